// File: Makefile
BIN := obj_dir/Vmem_stage_tb
SRCS := $(wildcard logic/*.sv logic/*.svh bench/*.sv)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		-f vlog.f --top-module mem_stage_tb -Mdir obj_dir -o Vmem_stage_tb

# status comes from the pass line in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir

// File: bench/mem_stage_tb.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_stage_tb;

  import mem_pkg::*;

  localparam int CLK_PERIOD      = 40;
  localparam int N_RESET_LOADS   = 8;
  localparam int N_WORDS         = 16;
  localparam int N_MIX           = 24;
  // directed requests of tests 3 to 6 stay below this
  localparam int N_DIRECTED      = 64;
  localparam int REQ_BUDGET      = N_RESET_LOADS + 2 * N_WORDS + N_MIX + N_DIRECTED;
  localparam int WATCHDOG_CYCLES = REQ_BUDGET * 8 + 100;
  localparam int MEM_BYTES       = 1 << (`WORD_ADDR_W + 2);

  logic              clk;
  logic              rst;
  logic              req;
  mem_op_t           op;
  byte_addr_t        addr;
  word_t             wdata;
  logic              busy;
  logic              done;
  logic              fault;
  word_t             rdata;
  logic [`LED_W-1:0] led;

  // prediction for the request in flight
  logic  exp_fault;
  word_t exp_rdata;
  logic  exp_long;

  // byte wide little-endian reference model
  logic [7:0]        ref_mem [MEM_BYTES];
  logic              model_wp;
  logic [`LED_W-1:0] model_led;
  word_t             model_count;

  int          err_count;
  int          pass_tests;
  int          fail_tests;
  int          test_err_base;
  int          req_issued;
  int          done_count;
  logic [31:0] rng_state;
  logic        accepted;

  mem_stage i_mem_stage (
    .clk   (clk),
    .rst   (rst),
    .req   (req),
    .op    (op),
    .addr  (addr),
    .wdata (wdata),
    .busy  (busy),
    .done  (done),
    .fault (fault),
    .rdata (rdata),
    .led   (led)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // edge where the DUT takes a request
  assign accepted = req && !busy;

  // every cycle with done high, one per completed request
  always @(posedge clk) begin
    if (!rst && done) begin
      done_count++;
    end
  end

  // word stores, register accesses and faults finish one cycle after accept
  assert property (@(posedge clk) disable iff (rst)
    (accepted && !exp_long) |=> (busy && !done) ##1 (done && !busy))
  else begin
    err_count++;
    $display("FAIL %0t short request latency or busy wrong", $time);
  end

  // loads and sub-word stores take one extra cycle
  assert property (@(posedge clk) disable iff (rst)
    (accepted && exp_long) |=> (busy && !done) ##1 (busy && !done) ##1 (done && !busy))
  else begin
    err_count++;
    $display("FAIL %0t long request latency or busy wrong", $time);
  end

  assert property (@(posedge clk) disable iff (rst)
    $rose(done) |-> (rdata == exp_rdata) && (fault == exp_fault))
  else begin
    err_count++;
    $display("FAIL %0t rdata %h fault %b, expected %h %b", $time, rdata, fault,
             exp_rdata, exp_fault);
  end

  // xorshift32
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic int size_of(input mem_op_t o);
    case (o)
      LB, LBU, SB: return 1;
      LH, LHU, SH: return 2;
      default:     return 4;
    endcase
  endfunction

  function automatic logic is_load_op(input mem_op_t o);
    return (o == LB) || (o == LBU) || (o == LH) || (o == LHU) || (o == LW);
  endfunction

  // sub-word mix for test 3
  function automatic mem_op_t mix_op(input logic [2:0] k);
    case (k)
      3'd0:    return SB;
      3'd1:    return SH;
      3'd2:    return LB;
      3'd3:    return LBU;
      3'd4:    return LH;
      3'd5:    return LHU;
      default: return LW;
    endcase
  endfunction

  function automatic byte_addr_t word_address(input logic [31:0] r);
    return {1'b0, r[`WORD_ADDR_W-1:0], 2'b00};
  endfunction

  function automatic byte_addr_t io_address(input logic [3:0] off);
    return {1'b1, {(`BYTE_ADDR_W-5){1'b0}}, off};
  endfunction

  // byte lane within the same word
  function automatic byte_addr_t at_lane(input byte_addr_t base, input logic [1:0] lane);
    return {base[`BYTE_ADDR_W-1:2], lane};
  endfunction

  // predict fault, rdata and latency class, then update the model
  task automatic predict(input mem_op_t o, input byte_addr_t a, input word_t d,
                         output logic f, output word_t r, output logic lng);
    int         size;
    int         ba;
    logic       io;
    logic       load;
    word_t      raw;
    logic [3:0] off;
    size = size_of(o);
    load = is_load_op(o);
    io   = a[`BYTE_ADDR_W-1];
    ba   = int'(a[`BYTE_ADDR_W-2:0]);
    off  = a[3:0];
    raw  = '0;
    r    = '0;
    lng  = 1'b0;
    f    = ((size == 2) && a[0]) || ((size == 4) && (a[1:0] != 2'b00)) ||
           (io && (size != 4)) || (!load && !io && model_wp);
    if (!f && io) begin
      if (load) begin
        case (off)
          `REG_CTRL:  r = {{(`DATA_W-1){1'b0}}, model_wp};
          `REG_LED:   r = {{(`DATA_W-`LED_W){1'b0}}, model_led};
          `REG_COUNT: r = model_count;
          default:    r = '0;
        endcase
      end else if (off == `REG_CTRL) begin
        model_wp = d[0];
      end else if (off == `REG_LED) begin
        model_led = d[`LED_W-1:0];
      end
    end else if (!f) begin
      lng = (o != SW);
      model_count = model_count + 32'd1;
      for (int i = 0; i < size; i++) begin
        if (load) begin
          raw[8*i +: 8] = ref_mem[ba + i];
        end else begin
          ref_mem[ba + i] = d[8*i +: 8];
        end
      end
      if (load) begin
        case (o)
          LB:      r = {{24{raw[7]}}, raw[7:0]};
          LH:      r = {{16{raw[15]}}, raw[15:0]};
          default: r = raw;
        endcase
      end
    end
  endtask

  // hold keeps req high through busy to probe double acceptance
  task automatic do_request(input mem_op_t o, input byte_addr_t a, input word_t d,
                            input logic hold);
    logic  f;
    word_t r;
    logic  lng;
    predict(o, a, d, f, r, lng);
    @(posedge clk);
    #2;
    req       = 1'b1;
    op        = o;
    addr      = a;
    wdata     = d;
    exp_fault = f;
    exp_rdata = r;
    exp_long  = lng;
    req_issued++;
    // busy seen means the last edge accepted it
    do begin
      @(posedge clk);
      #2;
    end while (!busy);
    if (!hold) begin
      req = 1'b0;
    end
    while (!done) begin
      @(posedge clk);
      #2;
    end
    req = 1'b0;
  endtask

  task automatic start_test();
    test_err_base = err_count;
  endtask

  task automatic end_test(input int num, input string name);
    if (err_count == test_err_base) begin
      pass_tests++;
      $display("test %0d %s: ok", num, name);
    end else begin
      fail_tests++;
      $display("test %0d %s: bad, %0d errors", num, name, err_count - test_err_base);
    end
  endtask

  // timeout guard
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the DUT stopped answering requests");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    byte_addr_t  base;
    byte_addr_t  a;
    byte_addr_t  addrs [N_WORDS];
    word_t       w0;
    word_t       w1;
    logic [31:0] r;
    mem_op_t     o;
    int          size;
    clk          = 1'b0;
    rst          = 1'b1;
    req          = 1'b0;
    op           = LW;
    addr         = '0;
    wdata        = '0;
    exp_fault    = 1'b0;
    exp_rdata    = '0;
    exp_long     = 1'b0;
    model_wp     = 1'b0;
    model_led    = '0;
    model_count  = '0;
    err_count    = 0;
    pass_tests   = 0;
    fail_tests   = 0;
    req_issued   = 0;
    done_count   = 0;
    rng_state    = 32'd94;
    for (int i = 0; i < MEM_BYTES; i++) begin
      ref_mem[i] = 8'h00;
    end
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;

    // test 1 checks the reset state
    start_test();
    assert (!busy && !done && !fault && (led == '0) && (rdata == '0))
    else begin
      err_count++;
      $display("FAIL %0t outputs not idle after reset", $time);
    end
    for (int i = 0; i < N_RESET_LOADS; i++) begin
      do_request(LW, word_address(next_rand()), '0, 1'b0);
    end
    end_test(1, "reset");

    // test 2 stores words then loads them back
    start_test();
    for (int i = 0; i < N_WORDS; i++) begin
      addrs[i] = word_address(next_rand());
      do_request(SW, addrs[i], next_rand(), 1'b0);
    end
    for (int i = 0; i < N_WORDS; i++) begin
      do_request(LW, addrs[i], '0, 1'b0);
    end
    end_test(2, "word store and load");

    // test 3 covers lane merges and extension over a 4-word region
    start_test();
    r    = next_rand();
    base = {1'b0, r[`WORD_ADDR_W-1:2], 4'h0};
    for (int i = 0; i < 4; i++) begin
      do_request(SW, {base[`BYTE_ADDR_W-1:4], 2'(i), 2'b00}, next_rand(), 1'b0);
    end
    for (int i = 0; i < 4; i++) begin
      do_request(SB, at_lane(base, 2'(i)), next_rand(), 1'b1);
      do_request(LB, at_lane(base, 2'(i)), '0, 1'b0);
      do_request(LBU, at_lane(base, 2'(i)), '0, 1'b1);
    end
    for (int i = 0; i < 4; i += 2) begin
      do_request(SH, at_lane(base, 2'(i)), next_rand(), 1'b0);
      do_request(LH, at_lane(base, 2'(i)), '0, 1'b1);
      do_request(LHU, at_lane(base, 2'(i)), '0, 1'b0);
    end
    do_request(LW, base, '0, 1'b0);
    for (int i = 0; i < N_MIX; i++) begin
      r    = next_rand();
      o    = mix_op(3'(r[6:4] % 3'd7));
      size = size_of(o);
      a    = {base[`BYTE_ADDR_W-1:4], r[3:0]};
      // keep each access aligned for its size
      if (size == 2) begin
        a[0] = 1'b0;
      end else if (size == 4) begin
        a[1:0] = 2'b00;
      end
      do_request(o, a, next_rand(), r[20]);
    end
    // a second acceptance would show up as an extra done pulse
    repeat (4) @(posedge clk);
    #2;
    assert (done_count == req_issued)
    else begin
      err_count++;
      $display("FAIL %0t %0d done pulses for %0d requests", $time, done_count,
               req_issued);
    end
    end_test(3, "sub-word merge and extension");

    // test 4 covers misaligned and sub-word I/O faults
    start_test();
    base = word_address(next_rand());
    do_request(SW, base, next_rand(), 1'b0);
    do_request(LH, at_lane(base, 2'd1), '0, 1'b0);
    do_request(LHU, at_lane(base, 2'd3), '0, 1'b0);
    do_request(LW, at_lane(base, 2'd2), '0, 1'b0);
    do_request(SH, at_lane(base, 2'd1), next_rand(), 1'b0);
    do_request(SW, at_lane(base, 2'd1), next_rand(), 1'b0);
    do_request(SW, at_lane(base, 2'd2), next_rand(), 1'b0);
    do_request(LB, io_address(`REG_LED), '0, 1'b0);
    do_request(SB, io_address(`REG_LED), next_rand(), 1'b0);
    do_request(LH, io_address(`REG_CTRL), '0, 1'b0);
    do_request(LW, base, '0, 1'b0);
    end_test(4, "faults");

    // test 5 covers write protect
    start_test();
    base = word_address(next_rand());
    w0   = next_rand();
    w1   = next_rand();
    do_request(SW, base, w0, 1'b0);
    do_request(SW, io_address(`REG_CTRL), 32'd1, 1'b0);
    do_request(SW, base, w1, 1'b0);
    do_request(SB, at_lane(base, 2'd3), w1, 1'b0);
    do_request(SH, at_lane(base, 2'd2), w1, 1'b0);
    do_request(LW, base, '0, 1'b0);
    do_request(LW, io_address(`REG_CTRL), '0, 1'b0);
    do_request(SW, io_address(`REG_CTRL), 32'd0, 1'b0);
    do_request(SW, base, w1, 1'b0);
    do_request(LW, base, '0, 1'b0);
    end_test(5, "write protect");

    // test 6 covers led and access count
    start_test();
    w0 = next_rand();
    do_request(SW, io_address(`REG_LED), w0, 1'b0);
    assert (led == model_led)
    else begin
      err_count++;
      $display("FAIL %0t led %h, expected %h", $time, led, model_led);
    end
    do_request(LW, io_address(`REG_LED), '0, 1'b0);
    do_request(LW, io_address(`REG_COUNT), '0, 1'b0);
    // count ignores writes
    do_request(SW, io_address(`REG_COUNT), next_rand(), 1'b0);
    do_request(LW, io_address(`REG_COUNT), '0, 1'b0);
    // offset 12 is unmapped
    do_request(LW, io_address(4'hc), '0, 1'b0);
    end_test(6, "led and count");

    @(posedge clk);
    #2;
    $display("tests ok %0d, tests bad %0d, errors %0d", pass_tests, fail_tests, err_count);
    if ((err_count == 0) && (fail_tests == 0)) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: logic/data_mem.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module data_mem (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  mem_en,
  input  logic                  mem_read,
  input  logic                  mem_write,
  input  mem_pkg::word_addr_t   mem_addr,
  input  mem_pkg::word_t        mem_wdata,
  output mem_pkg::word_t        mem_rdata
);

  import mem_pkg::*;

  // word storage, no byte enables
  word_t mem_data [`MEM_WORDS];

  // single port, read wins over write when both are asked
  always_ff @(posedge clk) begin
    if (rst) begin
      // clear every word plus the read register
      for (int i = 0; i < `MEM_WORDS; i++) begin
        mem_data[i] <= '0;
      end
      mem_rdata <= '0;
    end else if (mem_en) begin
      if (mem_read) begin
        // read data shows up the cycle after this edge
        mem_rdata <= mem_data[mem_addr];
      end else if (mem_write) begin
        mem_data[mem_addr] <= mem_wdata;
      end
    end
  end

endmodule

// File: logic/load_store_unit.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module load_store_unit (
  input  logic                  clk,
  input  logic                  rst,
  // core side
  input  logic                  req,
  input  mem_pkg::mem_op_t      op,
  input  mem_pkg::byte_addr_t   addr,
  input  mem_pkg::word_t        wdata,
  output logic                  busy,
  output logic                  done,
  output logic                  fault,
  output mem_pkg::word_t        rdata,
  // data memory side
  output logic                  mem_en,
  output logic                  mem_read,
  output logic                  mem_write,
  output mem_pkg::word_addr_t   mem_addr,
  output mem_pkg::word_t        mem_wdata,
  input  mem_pkg::word_t        mem_rdata,
  // register block side
  output logic                  reg_en,
  output logic                  reg_write,
  output logic [3:0]            reg_offset,
  output mem_pkg::word_t        reg_wdata,
  input  mem_pkg::word_t        reg_rdata,
  input  logic                  write_protect,
  output logic                  mem_access_done
);

  import mem_pkg::*;

  lsu_state_t state;

  // request held for the whole sequence
  mem_op_t    op_q;
  byte_addr_t addr_q;
  word_t      wdata_q;

  logic accept;

  // decode of the held request
  logic is_load;
  logic is_store;
  logic is_half;
  logic is_word;
  logic is_io;
  logic misaligned;
  logic io_subword;
  logic wp_block;
  logic fault_c;

  // lane handling
  logic [4:0] lane_shift;
  word_t      lane_mask;
  word_t      store_shifted;
  word_t      merged_word;
  word_t      load_shifted;
  word_t      load_val;

  // one request at a time, busy is the only back-pressure
  assign accept = (state == IDLE) && req && !busy;

  always_ff @(posedge clk) begin
    if (accept) begin
      op_q    <= op;
      addr_q  <= addr;
      wdata_q <= wdata;
    end
  end

  assign is_load  = (op_q == LB) || (op_q == LBU) || (op_q == LH) ||
                    (op_q == LHU) || (op_q == LW);
  assign is_store = !is_load;
  assign is_half  = (op_q == LH) || (op_q == LHU) || (op_q == SH);
  assign is_word  = (op_q == LW) || (op_q == SW);
  assign is_io    = addr_q[`BYTE_ADDR_W-1];

  // halfwords on even bytes, words on multiples of four
  assign misaligned = (is_half && addr_q[0]) || (is_word && (addr_q[1:0] != 2'b00));
  // registers are word only
  assign io_subword = is_io && !is_word;
  // write protect only guards data memory
  assign wp_block   = is_store && !is_io && write_protect;
  assign fault_c    = misaligned || io_subword || wp_block;

  // little-endian lane position in bits
  assign lane_shift    = {addr_q[1:0], 3'b000};
  assign lane_mask     = is_half ? (word_t'(16'hffff) << lane_shift)
                                 : (word_t'(8'hff) << lane_shift);
  assign store_shifted = wdata_q << lane_shift;
  // keep untouched lanes from the old word
  assign merged_word   = (mem_rdata & ~lane_mask) | (store_shifted & lane_mask);

  // move addressed lane down to bit 0, then extend
  assign load_shifted = mem_rdata >> lane_shift;

  always_comb begin
    case (op_q)
      LB:      load_val = {{24{load_shifted[7]}}, load_shifted[7:0]};
      LBU:     load_val = {24'h000000, load_shifted[7:0]};
      LH:      load_val = {{16{load_shifted[15]}}, load_shifted[15:0]};
      LHU:     load_val = {16'h0000, load_shifted[15:0]};
      default: load_val = mem_rdata;
    endcase
  end

  // memory port
  // loads and sub-word stores read first, word stores write straight away
  assign mem_read  = (state == ACCESS) && !fault_c && !is_io && (is_load || !is_word);
  assign mem_write = ((state == ACCESS) && !fault_c && !is_io && (op_q == SW)) ||
                     (state == MERGE);
  assign mem_en    = mem_read || mem_write;
  assign mem_addr  = addr_q[`WORD_ADDR_W+1:2];
  assign mem_wdata = (state == MERGE) ? merged_word : wdata_q;

  // register port, offset aliases across the window
  assign reg_en     = (state == ACCESS) && !fault_c && is_io;
  assign reg_write  = is_store;
  assign reg_offset = addr_q[3:0];
  assign reg_wdata  = wdata_q;

  // high in the last cycle of every completed memory request
  assign mem_access_done = ((state == ACCESS) && !fault_c && !is_io && (op_q == SW)) ||
                           (state == MERGE) || (state == RESULT);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      busy  <= 1'b0;
      done  <= 1'b0;
      fault <= 1'b0;
      rdata <= '0;
    end else begin
      // done is a single cycle pulse
      done <= 1'b0;
      case (state)
        IDLE: begin
          if (accept) begin
            state <= ACCESS;
            busy  <= 1'b1;
          end
        end
        ACCESS: begin
          if (fault_c) begin
            // nothing touched, finish now
            state <= IDLE;
            busy  <= 1'b0;
            done  <= 1'b1;
            fault <= 1'b1;
            rdata <= '0;
          end else if (is_io || (op_q == SW)) begin
            // register access or word store ends here
            state <= IDLE;
            busy  <= 1'b0;
            done  <= 1'b1;
            fault <= 1'b0;
            rdata <= (is_io && is_load) ? reg_rdata : '0;
          end else if (is_load) begin
            state <= RESULT;
          end else begin
            state <= MERGE;
          end
        end
        MERGE: begin
          // merged word written on this edge
          state <= IDLE;
          busy  <= 1'b0;
          done  <= 1'b1;
          fault <= 1'b0;
          rdata <= '0;
        end
        RESULT: begin
          state <= IDLE;
          busy  <= 1'b0;
          done  <= 1'b1;
          fault <= 1'b0;
          rdata <= load_val;
        end
        default: begin
          state <= IDLE;
          busy  <= 1'b0;
        end
      endcase
    end
  end

endmodule

// File: logic/mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// data path width
`define DATA_W 32

// word index into data memory
`define WORD_ADDR_W 15
`define MEM_WORDS (1 << `WORD_ADDR_W)

// core byte address, top bit picks the I/O window
`define BYTE_ADDR_W 18

// byte offsets inside the I/O window
`define REG_CTRL 4'h0
`define REG_LED 4'h4
`define REG_COUNT 4'h8

// led output width
`define LED_W 8

`endif

// File: logic/mem_pkg.sv
`include "mem_defs.svh"

package mem_pkg;

  // one data word
  typedef logic [`DATA_W-1:0] word_t;

  // index of a word in data memory
  typedef logic [`WORD_ADDR_W-1:0] word_addr_t;

  // byte address as issued by the core
  typedef logic [`BYTE_ADDR_W-1:0] byte_addr_t;

  // load and store flavours
  typedef enum logic [2:0] {
    LB,
    LBU,
    LH,
    LHU,
    LW,
    SB,
    SH,
    SW
  } mem_op_t;

  // load/store unit sequencer
  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    MERGE,
    RESULT
  } lsu_state_t;

endpackage

// File: logic/mem_stage.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req,
  input  mem_pkg::mem_op_t      op,
  input  mem_pkg::byte_addr_t   addr,
  input  mem_pkg::word_t        wdata,
  output logic                  busy,
  output logic                  done,
  output logic                  fault,
  output mem_pkg::word_t        rdata,
  output logic [`LED_W-1:0]     led
);

  import mem_pkg::*;

  // unit to data memory
  logic       mem_en;
  logic       mem_read;
  logic       mem_write;
  word_addr_t mem_addr;
  word_t      mem_wdata;
  word_t      mem_rdata;

  // unit to register block
  logic       reg_en;
  logic       reg_write;
  logic [3:0] reg_offset;
  word_t      reg_wdata;
  word_t      reg_rdata;
  logic       write_protect;
  logic       mem_access_done;

  load_store_unit i_load_store_unit (
    .clk             (clk),
    .rst             (rst),
    .req             (req),
    .op              (op),
    .addr            (addr),
    .wdata           (wdata),
    .busy            (busy),
    .done            (done),
    .fault           (fault),
    .rdata           (rdata),
    .mem_en          (mem_en),
    .mem_read        (mem_read),
    .mem_write       (mem_write),
    .mem_addr        (mem_addr),
    .mem_wdata       (mem_wdata),
    .mem_rdata       (mem_rdata),
    .reg_en          (reg_en),
    .reg_write       (reg_write),
    .reg_offset      (reg_offset),
    .reg_wdata       (reg_wdata),
    .reg_rdata       (reg_rdata),
    .write_protect   (write_protect),
    .mem_access_done (mem_access_done)
  );

  data_mem i_data_mem (
    .clk       (clk),
    .rst       (rst),
    .mem_en    (mem_en),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

  mmio_regs i_mmio_regs (
    .clk             (clk),
    .rst             (rst),
    .reg_en          (reg_en),
    .reg_write       (reg_write),
    .reg_offset      (reg_offset),
    .reg_wdata       (reg_wdata),
    .reg_rdata       (reg_rdata),
    .mem_access_done (mem_access_done),
    .write_protect   (write_protect),
    .led             (led)
  );

endmodule

// File: logic/mmio_regs.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module mmio_regs (
  input  logic               clk,
  input  logic               rst,
  input  logic               reg_en,
  input  logic               reg_write,
  input  logic [3:0]         reg_offset,
  input  mem_pkg::word_t     reg_wdata,
  output mem_pkg::word_t     reg_rdata,
  input  logic               mem_access_done,
  output logic               write_protect,
  output logic [`LED_W-1:0]  led
);

  import mem_pkg::*;

  // completed data memory accesses, read only
  word_t access_count;

  // control and led writes
  always_ff @(posedge clk) begin
    if (rst) begin
      write_protect <= 1'b0;
      led           <= '0;
    end else if (reg_en && reg_write) begin
      case (reg_offset)
        `REG_CTRL: write_protect <= reg_wdata[0];
        `REG_LED:  led <= reg_wdata[`LED_W-1:0];
        // count and unknown offsets drop the write
        default: ;
      endcase
    end
  end

  // counts on the completing cycle of each memory request
  always_ff @(posedge clk) begin
    if (rst) begin
      access_count <= '0;
    end else if (mem_access_done) begin
      access_count <= access_count + 1'b1;
    end
  end

  // read mux, sampled by the unit on the access edge
  always_comb begin
    case (reg_offset)
      `REG_CTRL:  reg_rdata = {{(`DATA_W-1){1'b0}}, write_protect};
      `REG_LED:   reg_rdata = {{(`DATA_W-`LED_W){1'b0}}, led};
      `REG_COUNT: reg_rdata = access_count;
      default:    reg_rdata = '0;
    endcase
  end

endmodule

// File: vlog.f
+incdir+logic
logic/mem_pkg.sv
logic/data_mem.sv
logic/load_store_unit.sv
logic/mmio_regs.sv
logic/mem_stage.sv
bench/mem_stage_tb.sv
